/* common/port_config.svh */
`ifndef PORT_CONFIG_SVH
`define PORT_CONFIG_SVH

// byte address width on the CPU and bus side
`define PORT_ADDR_W 32

// direct-mapped lines of one word each, must be a power of two
`define CACHE_LINES 8

`endif

/* common/busop_pkg.sv */
package busop_pkg;

	// operation codes as seen on the CPU side
	typedef enum logic [2:0] {
		READB  = 3'd0,
		READH  = 3'd1,
		READW  = 3'd2,
		READBU = 3'd3,
		READHU = 3'd4,
		WRITEB = 3'd5,
		WRITEH = 3'd6,
		WRITEW = 3'd7
	} busop_t;

	// number of bytes moved by one operation
	function automatic logic [2:0] op_bytes(busop_t op);
		case (op)
			READW, WRITEW: op_bytes = 3'd4;
			READH, READHU, WRITEH: op_bytes = 3'd2;
			default: op_bytes = 3'd1;
		endcase
	endfunction

	function automatic logic op_is_write(busop_t op);
		case (op)
			WRITEB, WRITEH, WRITEW: op_is_write = 1'b1;
			default: op_is_write = 1'b0;
		endcase
	endfunction

	// only the narrow signed loads need extension with the sign bit
	function automatic logic op_is_signed(busop_t op);
		case (op)
			READB, READH: op_is_signed = 1'b1;
			default: op_is_signed = 1'b0;
		endcase
	endfunction

endpackage

/* common/port_ifs.sv */
`timescale 1ns/1ns
`include "port_config.svh"

// four-phase link between the controller and the read cache
interface cache_if;
	logic req;
	logic ack;
	// high for an update, low for a lookup
	logic update;
	busop_pkg::busop_t op;
	logic [`PORT_ADDR_W-1:0] addr;
	logic [31:0] data;
	logic hit;
	logic [31:0] rdata;

	modport ctrl (output req, update, op, addr, data, input ack, hit, rdata);
	modport cache (input req, update, op, addr, data, output ack, hit, rdata);
endinterface

// four-phase link between the controller and the byte bus master
interface bus_if;
	logic req;
	logic ack;
	busop_pkg::busop_t op;
	logic [`PORT_ADDR_W-1:0] addr;
	logic [31:0] wdata;
	// already extended to 32 bits for narrow reads
	logic [31:0] rdata;

	modport ctrl (output req, op, addr, wdata, input ack, rdata);
	modport master (input req, op, addr, wdata, output ack, rdata);
endinterface

/* cache/read_cache.sv */
`timescale 1ns/1ns
`include "port_config.svh"

module read_cache (
	input logic CLK_I,
	input logic RST_I,
	cache_if.cache port
);

	localparam int AW = `PORT_ADDR_W;
	localparam int IDX_W = $clog2(`CACHE_LINES);
	localparam int TAG_W = AW - IDX_W - 2;

	logic [`CACHE_LINES-1:0] valid;
	logic [TAG_W-1:0] tag_mem [`CACHE_LINES];
	logic [31:0] data_mem [`CACHE_LINES];

	logic start;
	logic lookup;
	logic update;
	logic aligned;
	logic store;
	logic [AW-1:0] last_addr;
	logic [IDX_W-1:0] idx;
	logic [IDX_W-1:0] last_idx;
	logic [TAG_W-1:0] tag;

	// a request counts once, in the cycle before its ack rises
	assign start = port.req && !port.ack;
	assign lookup = start && !port.update;
	assign update = start && port.update;

	assign aligned = port.addr[1:0] == 2'b00;
	assign store = aligned
		&& (port.op == busop_pkg::READW || port.op == busop_pkg::WRITEW);

	// last byte touched, it may sit in the next line
	assign last_addr = port.addr + AW'(busop_pkg::op_bytes(port.op) - 3'd1);
	assign idx = port.addr[2 +: IDX_W];
	assign last_idx = last_addr[2 +: IDX_W];
	assign tag = port.addr[AW-1 -: TAG_W];

	always_ff @(posedge CLK_I) begin
		if (RST_I) begin
			port.ack <= 1'b0;
			port.hit <= 1'b0;
			valid <= '0;
		end else begin
			port.ack <= port.req;
			if (lookup) begin
				// only aligned word loads are served
				port.hit <= port.op == busop_pkg::READW && aligned
					&& valid[idx] && tag_mem[idx] == tag;
			end
			if (update) begin
				port.hit <= 1'b0;
				if (store) begin
					valid[idx] <= 1'b1;
				end else if (busop_pkg::op_is_write(port.op)) begin
					// partial or unaligned write drops every line it touches
					valid[idx] <= 1'b0;
					valid[last_idx] <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge CLK_I) begin
		if (lookup) begin
			port.rdata <= data_mem[idx];
		end
		if (update && store) begin
			tag_mem[idx] <= tag;
			data_mem[idx] <= port.data;
		end
	end

endmodule

/* wb8/wb8_master.sv */
`timescale 1ns/1ns
`include "port_config.svh"

module wb8_master (
	input logic CLK_I,
	input logic RST_I,
	bus_if.master port,
	output logic [`PORT_ADDR_W-1:0] ADR_O,
	output logic [7:0] DAT_O,
	output logic WE_O,
	output logic CYC_O,
	output logic STB_O,
	input logic ACK_I,
	input logic [7:0] DAT_I
);

	localparam int AW = `PORT_ADDR_W;

	localparam logic [1:0] S_IDLE = 2'd0;
	localparam logic [1:0] S_RUN  = 2'd1;
	localparam logic [1:0] S_DONE = 2'd2;

	logic [1:0] state;
	// bytes strobed so far and bytes acked so far
	logic [2:0] byte_cnt;
	logic [2:0] ack_cnt;
	logic [2:0] n_bytes;
	logic [1:0] byte_sel;
	logic [31:0] raw;
	logic sign;

	logic start;
	logic strobe_next;
	logic byte_acked;
	logic last_ack;

	assign n_bytes = busop_pkg::op_bytes(port.op);

	assign start = state == S_IDLE && port.req;
	// one idle cycle with STB_O low separates two strobes
	assign strobe_next = state == S_RUN && !STB_O && byte_cnt != n_bytes;
	assign byte_acked = state == S_RUN && STB_O && ACK_I;
	assign last_ack = byte_acked && ack_cnt + 3'd1 == n_bytes;

	// first byte goes out together with CYC_O
	assign byte_sel = start ? 2'd0 : byte_cnt[1:0];

	always_ff @(posedge CLK_I) begin
		if (RST_I) begin
			state <= S_IDLE;
			CYC_O <= 1'b0;
			STB_O <= 1'b0;
			WE_O <= 1'b0;
			port.ack <= 1'b0;
			byte_cnt <= 3'd0;
			ack_cnt <= 3'd0;
		end else begin
			case (state)
				S_IDLE: begin
					if (start) begin
						state <= S_RUN;
						CYC_O <= 1'b1;
						STB_O <= 1'b1;
						WE_O <= busop_pkg::op_is_write(port.op);
						byte_cnt <= 3'd1;
						ack_cnt <= 3'd0;
					end
				end
				S_RUN: begin
					if (byte_acked) begin
						STB_O <= 1'b0;
						ack_cnt <= ack_cnt + 3'd1;
						if (last_ack) begin
							CYC_O <= 1'b0;
							WE_O <= 1'b0;
							port.ack <= 1'b1;
							state <= S_DONE;
						end
					end else if (strobe_next) begin
						STB_O <= 1'b1;
						byte_cnt <= byte_cnt + 3'd1;
					end
				end
				S_DONE: begin
					// hold ack until the controller lets go
					if (!port.req) begin
						port.ack <= 1'b0;
						state <= S_IDLE;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge CLK_I) begin
		if (start || strobe_next) begin
			ADR_O <= port.addr + AW'(byte_sel);
			DAT_O <= port.wdata[{byte_sel, 3'b000} +: 8];
		end
		// little endian, byte i lands at bit 8i
		if (byte_acked) begin
			raw[{ack_cnt[1:0], 3'b000} +: 8] <= DAT_I;
		end
	end

	assign sign = busop_pkg::op_is_signed(port.op);

	always_comb begin
		case (n_bytes)
			3'd1: port.rdata = {{24{sign & raw[7]}}, raw[7:0]};
			3'd2: port.rdata = {{16{sign & raw[15]}}, raw[15:0]};
			default: port.rdata = raw;
		endcase
	end

endmodule

/* hdl/port_controller.sv */
`timescale 1ns/1ns
`include "port_config.svh"

module port_controller (
	input logic CLK_I,
	input logic RST_I,
	input logic cpu_req,
	input busop_pkg::busop_t cpu_op,
	input logic [`PORT_ADDR_W-1:0] cpu_addr,
	input logic [31:0] cpu_wdata,
	output logic cpu_ack,
	output logic [31:0] cpu_rdata,
	cache_if.ctrl cache,
	bus_if.ctrl bus
);

	localparam logic [2:0] S_IDLE    = 3'd0;
	localparam logic [2:0] S_LOOKUP  = 3'd1;
	localparam logic [2:0] S_BUS     = 3'd2;
	localparam logic [2:0] S_UPDATE  = 3'd3;
	localparam logic [2:0] S_ANSWER  = 3'd4;
	localparam logic [2:0] S_RELEASE = 3'd5;

	logic [2:0] state;
	logic bus_done;
	logic accept;

	// latched CPU request and the word returned by the bus
	busop_pkg::busop_t op_q;
	logic [`PORT_ADDR_W-1:0] addr_q;
	logic [31:0] wdata_q;
	logic [31:0] word_q;

	assign accept = state == S_IDLE && cpu_req;

	// req is high exactly while a handshake state waits for its ack
	assign cache.req = state == S_LOOKUP || state == S_UPDATE;
	assign cache.update = state == S_UPDATE;
	assign cache.op = op_q;
	assign cache.addr = addr_q;
	assign cache.data = busop_pkg::op_is_write(op_q) ? wdata_q : word_q;

	assign bus.req = state == S_BUS;
	assign bus.op = op_q;
	assign bus.addr = addr_q;
	assign bus.wdata = wdata_q;

	// on a hit the lookup goes out on the edge that sees cpu_req
	// and the cache acks one edge later
	// the answer is registered on the edge after the ack
	always_ff @(posedge CLK_I) begin
		if (RST_I) begin
			state <= S_IDLE;
			cpu_ack <= 1'b0;
			bus_done <= 1'b0;
		end else begin
			case (state)
				S_IDLE: begin
					if (accept) begin
						bus_done <= 1'b0;
						// writes skip the lookup and go to the bus
						state <= busop_pkg::op_is_write(cpu_op) ? S_BUS : S_LOOKUP;
					end
				end
				S_LOOKUP: begin
					if (cache.ack && cache.hit) begin
						cpu_ack <= 1'b1;
						state <= S_ANSWER;
					end else if (cache.ack) begin
						state <= S_RELEASE;
					end
				end
				S_BUS: begin
					if (bus.ack) begin
						bus_done <= 1'b1;
						state <= S_RELEASE;
					end
				end
				S_RELEASE: begin
					if (!cache.ack && !bus.ack) begin
						state <= bus_done ? S_UPDATE : S_BUS;
					end
				end
				S_UPDATE: begin
					if (cache.ack) begin
						cpu_ack <= 1'b1;
						state <= S_ANSWER;
					end
				end
				S_ANSWER: begin
					if (!cpu_req) begin
						cpu_ack <= 1'b0;
						state <= S_IDLE;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge CLK_I) begin
		if (accept) begin
			op_q <= cpu_op;
			addr_q <= cpu_addr;
			wdata_q <= cpu_wdata;
		end
		if (state == S_BUS && bus.ack) begin
			word_q <= bus.rdata;
		end
		if (state == S_LOOKUP && cache.ack && cache.hit) begin
			cpu_rdata <= cache.rdata;
		end
		if (state == S_UPDATE && cache.ack) begin
			cpu_rdata <= word_q;
		end
	end

endmodule

/* hdl/mem_port_top.sv */
`timescale 1ns/1ns
`include "port_config.svh"

module mem_port_top (
	input logic CLK_I,
	input logic RST_I,

	// CPU request port, four-phase req/ack
	input logic cpu_req,
	input busop_pkg::busop_t cpu_op,
	input logic [`PORT_ADDR_W-1:0] cpu_addr,
	input logic [31:0] cpu_wdata,
	output logic cpu_ack,
	output logic [31:0] cpu_rdata,

	// 8-bit Wishbone master side
	output logic [`PORT_ADDR_W-1:0] ADR_O,
	output logic [7:0] DAT_O,
	output logic WE_O,
	output logic CYC_O,
	output logic STB_O,
	input logic ACK_I,
	input logic [7:0] DAT_I
);

	cache_if cache_link ();
	bus_if bus_link ();

	port_controller u_ctrl (
		.CLK_I(CLK_I),
		.RST_I(RST_I),
		.cpu_req(cpu_req),
		.cpu_op(cpu_op),
		.cpu_addr(cpu_addr),
		.cpu_wdata(cpu_wdata),
		.cpu_ack(cpu_ack),
		.cpu_rdata(cpu_rdata),
		.cache(cache_link.ctrl),
		.bus(bus_link.ctrl)
	);

	read_cache u_cache (
		.CLK_I(CLK_I),
		.RST_I(RST_I),
		.port(cache_link.cache)
	);

	wb8_master u_master (
		.CLK_I(CLK_I),
		.RST_I(RST_I),
		.port(bus_link.master),
		.ADR_O(ADR_O),
		.DAT_O(DAT_O),
		.WE_O(WE_O),
		.CYC_O(CYC_O),
		.STB_O(STB_O),
		.ACK_I(ACK_I),
		.DAT_I(DAT_I)
	);

endmodule

/* verif/mem_port_assert.sv */
`timescale 1ns/1ns
`include "port_config.svh"

module mem_port_assert (
	input logic CLK_I,
	input logic RST_I,
	input logic cpu_req,
	input logic cpu_ack,
	input logic [`PORT_ADDR_W-1:0] ADR_O,
	input logic [7:0] DAT_O,
	input logic WE_O,
	input logic CYC_O,
	input logic STB_O,
	input logic ACK_I
);

	// failed properties so far
	int fail_cnt = 0;

	stb_in_cycle: assert property (@(posedge CLK_I) disable iff (RST_I) STB_O |-> CYC_O)
		else begin
			$error("STB_O high without CYC_O");
			fail_cnt++;
		end

	// a strobe waiting for ACK_I holds its address, data and direction
	stb_hold: assert property (@(posedge CLK_I) disable iff (RST_I)
		STB_O && !ACK_I |=> $stable(ADR_O) && $stable(DAT_O) && $stable(WE_O))
		else begin
			$error("Wishbone outputs changed while the strobe waited");
			fail_cnt++;
		end

	// the edge that raised cpu_ack must have seen cpu_req high
	ack_needs_req: assert property (@(posedge CLK_I) disable iff (RST_I)
		$rose(cpu_ack) |-> $past(cpu_req))
		else begin
			$error("cpu_ack rose without cpu_req");
			fail_cnt++;
		end

	ack_release: assert property (@(posedge CLK_I) disable iff (RST_I)
		cpu_ack && !cpu_req |=> !cpu_ack)
		else begin
			$error("cpu_ack did not fall after cpu_req fell");
			fail_cnt++;
		end

	reset_quiet: assert property (@(posedge CLK_I) RST_I |=> !cpu_ack && !CYC_O && !STB_O)
		else begin
			$error("outputs active during or right after reset");
			fail_cnt++;
		end

endmodule

bind mem_port_top mem_port_assert protocol_checks (.*);

/* verif/tb_top.sv */
`timescale 1ns/1ns
`include "port_config.svh"

module tb_top;

	localparam int N_RANDOM = 150;
	localparam int N_SEQ = 6;
	localparam int SEQ_TXNS = 24;
	localparam int CLK_PERIOD = 10;
	// worst case per transaction, a slow four-byte bus access plus the cache steps
	localparam int TXN_CYCLES = 40;
	localparam int WATCHDOG_NS = (N_RANDOM + N_SEQ * SEQ_TXNS) * TXN_CYCLES * CLK_PERIOD + 2000;
	localparam logic [31:0] WIN_BASE = 32'h4000_0000;
	// aligned slots that leave room for the conflicting line and a spanning word
	localparam int SLOTS = (256 - 4 * `CACHE_LINES - 8) / 4;

	logic CLK_I;
	logic RST_I;
	logic cpu_req;
	busop_pkg::busop_t cpu_op;
	logic [`PORT_ADDR_W-1:0] cpu_addr;
	logic [31:0] cpu_wdata;
	logic cpu_ack;
	logic [31:0] cpu_rdata;
	logic [`PORT_ADDR_W-1:0] ADR_O;
	logic [7:0] DAT_O;
	logic WE_O;
	logic CYC_O;
	logic STB_O;
	logic ACK_I;
	logic [7:0] DAT_I;

	// bus slave storage and the expected memory contents
	logic [7:0] wb_mem [256];
	logic [7:0] ref_mem [256];
	logic [31:0] stim_state = 32'd3621;
	logic [31:0] bus_state = 32'd3621;
	int errors = 0;

	mem_port_top DUT (.*);

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1103515245 + 32'd12345;
	endfunction

	function automatic logic [15:0] next_stim();
		stim_state = lcg_next(stim_state);
		return stim_state[30:15];
	endfunction

	function automatic logic [31:0] random_word();
		return {next_stim(), next_stim()};
	endfunction

	function automatic int access_bytes(input busop_pkg::busop_t op);
		case (op)
			busop_pkg::READW, busop_pkg::WRITEW: return 4;
			busop_pkg::READH, busop_pkg::READHU, busop_pkg::WRITEH: return 2;
			default: return 1;
		endcase
	endfunction

	function automatic logic is_store(input busop_pkg::busop_t op);
		return op == busop_pkg::WRITEB || op == busop_pkg::WRITEH || op == busop_pkg::WRITEW;
	endfunction

	// little-endian bytes from the reference, extended by the load type
	function automatic logic [31:0] expect_read(input busop_pkg::busop_t op,
		input logic [31:0] addr);
		logic [31:0] word;
		word = '0;
		for (int i = 0; i < access_bytes(op); i++) begin
			word[8*i +: 8] = ref_mem[8'(addr + 32'(i))];
		end
		if (op == busop_pkg::READB) begin
			word[31:8] = {24{word[7]}};
		end else if (op == busop_pkg::READH) begin
			word[31:16] = {16{word[15]}};
		end
		return word;
	endfunction

	initial begin
		CLK_I = 1'b0;
		forever #(CLK_PERIOD / 2) CLK_I = ~CLK_I;
	end

	// byte slave, acks each strobe after 0 to 3 extra cycles
	initial begin
		int dly;
		ACK_I = 1'b0;
		DAT_I = 8'd0;
		forever begin
			@(posedge CLK_I);
			#1;
			ACK_I = 1'b0;
			if (STB_O) begin
				bus_state = lcg_next(bus_state);
				dly = int'(bus_state[17:16]);
				repeat (dly) begin
					@(posedge CLK_I);
					#1;
				end
				if (WE_O) begin
					wb_mem[ADR_O[7:0]] = DAT_O;
				end else begin
					DAT_I = wb_mem[ADR_O[7:0]];
				end
				ACK_I = 1'b1;
			end
		end
	end

	// one full four-phase CPU transaction, called 1 ns after a rising edge
	task automatic cpu_access(input busop_pkg::busop_t op, input logic [31:0] addr,
		input logic [31:0] wdata, output logic [31:0] rdata, output logic bus_seen,
		output int cycles);
		bus_seen = 1'b0;
		cycles = 0;
		cpu_op = op;
		cpu_addr = addr;
		cpu_wdata = wdata;
		cpu_req = 1'b1;
		while (!cpu_ack) begin
			@(posedge CLK_I);
			#1;
			cycles++;
			if (CYC_O) bus_seen = 1'b1;
		end
		rdata = cpu_rdata;
		cpu_req = 1'b0;
		while (cpu_ack) begin
			@(posedge CLK_I);
			#1;
			if (CYC_O) bus_seen = 1'b1;
		end
		if (is_store(op)) begin
			for (int i = 0; i < access_bytes(op); i++) begin
				ref_mem[8'(addr + 32'(i))] = wdata[8*i +: 8];
			end
		end
	endtask

	task automatic do_op(input busop_pkg::busop_t op, input logic [31:0] addr,
		input logic [31:0] wdata, output logic bus_seen, output int cycles);
		logic [31:0] exp_word;
		logic [31:0] got;
		exp_word = expect_read(op, addr);
		cpu_access(op, addr, wdata, got, bus_seen, cycles);
		if (!is_store(op)) begin
			assert (got == exp_word) else begin
				$display("CHECK FAILED at %0t: %s at %h returned %h, expected %h",
					$time, op.name(), addr, got, exp_word);
				errors++;
			end
		end
	endtask

	task automatic expect_hit(input logic [31:0] addr);
		logic seen;
		int cyc;
		do_op(busop_pkg::READW, addr, 32'd0, seen, cyc);
		assert (!seen && cyc == 3) else begin
			$display("CHECK FAILED at %0t: READW at %h should hit, bus %0b, ack after %0d cycles",
				$time, addr, seen, cyc);
			errors++;
		end
	endtask

	task automatic expect_miss(input logic [31:0] addr);
		logic seen;
		int cyc;
		do_op(busop_pkg::READW, addr, 32'd0, seen, cyc);
		assert (seen) else begin
			$display("CHECK FAILED at %0t: READW at %h should use the bus", $time, addr);
			errors++;
		end
	endtask

	task automatic cache_sequence(input logic [31:0] a);
		logic seen;
		int cyc;
		do_op(busop_pkg::READW, a, 32'd0, seen, cyc);
		expect_hit(a);
		// unaligned word loads never come from the cache
		expect_miss(a + 32'd1);
		expect_miss(a + 32'd1);
		do_op(busop_pkg::WRITEB, a + 32'd2, random_word(), seen, cyc);
		expect_miss(a);
		expect_hit(a);
		do_op(busop_pkg::WRITEH, a, random_word(), seen, cyc);
		expect_miss(a);
		expect_hit(a);
		// full aligned write keeps the line valid with the new word
		do_op(busop_pkg::WRITEW, a, random_word(), seen, cyc);
		expect_hit(a);
		do_op(busop_pkg::READW, a + 32'(4 * `CACHE_LINES), 32'd0, seen, cyc);
		expect_miss(a);
		do_op(busop_pkg::READW, a + 32'd4, 32'd0, seen, cyc);
		expect_hit(a);
		expect_hit(a + 32'd4);
		// word write across two lines drops both
		do_op(busop_pkg::WRITEW, a + 32'd2, random_word(), seen, cyc);
		expect_miss(a);
		expect_miss(a + 32'd4);
		do_op(busop_pkg::READHU, a + 32'd1, 32'd0, seen, cyc);
		do_op(busop_pkg::READB, a + 32'd6, 32'd0, seen, cyc);
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("timeout: the CPU handshake did not complete within %0d ns", WATCHDOG_NS);
		$display("RESULT: FAIL");
		$finish;
	end

	initial begin
		logic [15:0] r;
		logic seen;
		int cyc;
		int total;
		RST_I = 1'b1;
		cpu_req = 1'b0;
		cpu_op = busop_pkg::READB;
		cpu_addr = '0;
		cpu_wdata = 32'd0;
		for (int i = 0; i < 256; i++) begin
			wb_mem[i] = 8'(i * 29 + 83);
			ref_mem[i] = 8'(i * 29 + 83);
		end
		repeat (4) @(posedge CLK_I);
		#1;
		RST_I = 1'b0;

		for (int n = 0; n < N_RANDOM; n++) begin
			r = next_stim();
			do_op(busop_pkg::busop_t'(r[2:0]), WIN_BASE + 32'(r[10:3]), random_word(), seen,
				cyc);
		end
		for (int n = 0; n < N_SEQ; n++) begin
			cache_sequence(WIN_BASE + 32'd4 * (32'(next_stim()) % 32'(SLOTS)));
		end

		total = errors + DUT.protocol_checks.fail_cnt;
		$display("checks done: %0d data errors, %0d protocol errors", errors,
			DUT.protocol_checks.fail_cnt);
		if (total == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

/* tb.f */
+incdir+common
common/busop_pkg.sv
common/port_ifs.sv
cache/read_cache.sv
wb8/wb8_master.sv
hdl/port_controller.sv
hdl/mem_port_top.sv
verif/mem_port_assert.sv
verif/tb_top.sv

/* run.sh */
#!/bin/sh
# build from tb.f, run, and pass only when the pass line shows up
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_top -f tb.f -o tb_sim &&
out=$(./obj_dir/tb_sim +verilator+error+limit+1000 2>&1 || echo "simulator exited with an error") &&
printf '%s\n' "$out" &&
printf '%s\n' "$out" | grep -qx 'RESULT: PASS' &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
